//--- design/excPkg.sv
`default_nettype none

package excPkg;

  // Instruction address
  typedef logic [31:0] pcT;

  // One bit per exception source, see Cause* below
  typedef logic [6:0] causeT;

  // Per-stage flush bits, see Flush* below
  typedef logic [3:0] flushT;

  // CPSR mode field values entered on an exception
  typedef enum logic [4:0] {
    ModeFiq = 5'b10001,
    ModeIrq = 5'b10010,
    ModeSvc = 5'b10011,
    ModeAbt = 5'b10111,
    ModeUnd = 5'b11011
  } excModeT;

  // Bit positions inside causeT, lowest first
  localparam int CauseReset         = 0;
  localparam int CauseUndefined     = 1;
  localparam int CauseSwi           = 2;
  localparam int CausePrefetchAbort = 3;
  localparam int CauseDataAbort     = 4;
  localparam int CauseIrq           = 5;
  localparam int CauseFiq           = 6;

  // Bit positions inside flushT
  localparam int FlushW = 0;
  localparam int FlushM = 1;
  localparam int FlushE = 2;
  localparam int FlushD = 3;

  // Vector table byte offsets
  localparam pcT VecReset         = 32'h0000_0000;
  localparam pcT VecUndefined     = 32'h0000_0004;
  localparam pcT VecSwi           = 32'h0000_0008;
  localparam pcT VecPrefetchAbort = 32'h0000_000C;
  localparam pcT VecDataAbort     = 32'h0000_0010;
  localparam pcT VecIrq           = 32'h0000_0018;
  localparam pcT VecFiq           = 32'h0000_001C;

endpackage

`default_nettype wire

//--- design/exceptionHandler.sv
`default_nettype none

module exceptionHandler (
  input  logic          clk,
  input  logic          rstN,
  input  logic          undefinedInstrE,
  input  logic          swiE,
  input  logic          prefetchAbortE,
  input  logic          dataAbort,
  input  logic          irq,
  input  logic          fiq,
  input  logic          irqEnabled,
  input  logic          fiqEnabled,
  input  logic          clearD,
  input  logic          clearM,
  output logic          dataAbortCycle2,
  output logic          clearF,
  output logic          stallD,
  output logic          resetMicrop,
  output logic          savePc,
  output logic          pcInSelect,
  output excPkg::flushT flush,
  output excPkg::causeT cause
);

  import excPkg::*;

  // Enables as seen after the CPSR update settles
  logic irqEnSync;
  logic fiqEnSync;

  // Qualified interrupt requests
  logic irqReq;
  logic fiqReq;

  // Any exception caught in E
  logic eStageExc;

  // Interrupt taken this cycle
  logic irqAssert;
  logic fiqAssert;

  // Second abort cycle is the abort seen by the rest of the core
  always_ff @(posedge clk or negedge rstN) begin
    if (!rstN) begin
      dataAbortCycle2 <= 1'b0;
      irqEnSync       <= 1'b0;
      fiqEnSync       <= 1'b0;
    end else begin
      dataAbortCycle2 <= dataAbort;
      // CPSR changes mid-cycle and settles by the next rising edge
      irqEnSync       <= irqEnabled;
      fiqEnSync       <= fiqEnabled;
    end
  end

  assign irqReq    = irq & irqEnSync;
  assign fiqReq    = fiq & fiqEnSync;
  assign eStageExc = prefetchAbortE | undefinedInstrE | swiE;

  // Priority runs data abort, E-stage, FIQ, then IRQ
  always_comb begin
    flush     = '0;
    stallD    = 1'b0;
    clearF    = 1'b0;
    irqAssert = 1'b0;
    fiqAssert = 1'b0;
    if (dataAbort || dataAbortCycle2) begin
      // Caught in M so D, M and W always go
      flush[FlushD] = 1'b1;
      flush[FlushM] = 1'b1;
      flush[FlushW] = 1'b1;
      // E flush and D stall only in the first cycle
      flush[FlushE] = dataAbort;
      stallD        = dataAbort;
    end else if (eStageExc) begin
      // Caught in E where the excepting instruction stays
      flush[FlushD] = 1'b1;
      flush[FlushM] = 1'b1;
    end else if (fiqReq || irqReq) begin
      // Keep injecting the token until it shows up in M
      clearF        = ~clearM;
      // Hold D and feed bubbles into E while draining
      stallD        = clearD & ~clearM;
      flush[FlushE] = clearD & ~clearM;
      // Older instructions retired so the interrupt is taken
      flush[FlushD] = clearM;
      fiqAssert     = fiqReq & clearM;
      irqAssert     = ~fiqReq & clearM;
    end
  end

  // Cause vector with the reset bit following rstN
  assign cause[CauseReset]         = ~rstN;
  assign cause[CauseUndefined]     = undefinedInstrE;
  assign cause[CauseSwi]           = swiE;
  assign cause[CausePrefetchAbort] = prefetchAbortE;
  assign cause[CauseDataAbort]     = dataAbortCycle2;
  assign cause[CauseIrq]           = irqAssert;
  assign cause[CauseFiq]           = fiqAssert;

  assign savePc      = |cause;
  // High selects the E-side PC and low the D-side PC for interrupts
  assign pcInSelect  = eStageExc | dataAbortCycle2;
  assign resetMicrop = dataAbort;

  // Abort in M flushes M and no second abort can follow directly
  daNoOverlap : assert property (@(posedge clk) disable iff (!rstN)
    !(dataAbort && dataAbortCycle2));

  // The D flush removes the token so an interrupt is taken once per drain
  oneAssert : assert property (@(posedge clk) disable iff (!rstN)
    (irqAssert || fiqAssert) |=> !(irqAssert || fiqAssert));

endmodule

`default_nettype wire

//--- design/clearTokenPipe.sv
`default_nettype none

module clearTokenPipe (
  input  logic          clk,
  input  logic          rstN,
  input  logic          clearF,
  input  logic          hazardStallD,
  input  excPkg::flushT flush,
  output logic          clearD,
  output logic          clearM
);

  import excPkg::*;

  // Token position in E
  logic clearE;

  // Data abort is the only source that flushes E and W together
  logic abortKillE;

  assign abortKillE = flush[FlushE] & flush[FlushW];

  always_ff @(posedge clk or negedge rstN) begin
    if (!rstN) begin
      clearD <= 1'b0;
      clearE <= 1'b0;
      clearM <= 1'b0;
    end else begin
      // D marker ignores the exception stall and only a hazard holds it
      if (flush[FlushD]) begin
        clearD <= 1'b0;
      end else if (!hazardStallD) begin
        clearD <= clearF;
      end
      // One token leaves D per drain
      // D stays marked while stalled and a second copy is blocked
      // once E or M already carries it
      clearE <= clearD & ~clearE & ~clearM & ~abortKillE;
      // Interrupt flush of E never reaches here
      clearM <= clearE & ~flush[FlushM];
    end
  end

  // No new token enters D once one sits in M
  // D empties unless a hazard holds it
  noStaleToken : assert property (@(posedge clk) disable iff (!rstN)
    (clearM && !hazardStallD) |=> !clearD);

endmodule

`default_nettype wire

//--- design/vectorSelect.sv
`default_nettype none

module vectorSelect #(
  parameter excPkg::pcT VectorBase = '0
) (
  input  excPkg::causeT cause,
  input  excPkg::pcT    pcNext,
  output excPkg::pcT    pcFetch
);

  import excPkg::*;

  // Offset of the winning cause
  pcT   vecOffset;
  // Some cause is present
  logic anyCause;

  assign anyCause = |cause;

  // Reset wins while held, then FIQ down to undefined
  always_comb begin
    if (cause[CauseReset]) begin
      vecOffset = VecReset;
    end else if (cause[CauseFiq]) begin
      vecOffset = VecFiq;
    end else if (cause[CauseIrq]) begin
      vecOffset = VecIrq;
    end else if (cause[CauseDataAbort]) begin
      vecOffset = VecDataAbort;
    end else if (cause[CausePrefetchAbort]) begin
      vecOffset = VecPrefetchAbort;
    end else if (cause[CauseSwi]) begin
      vecOffset = VecSwi;
    end else if (cause[CauseUndefined]) begin
      vecOffset = VecUndefined;
    end else begin
      // Unused, pcNext selected below
      vecOffset = VecReset;
    end
  end

  // Base is aligned, add never carries into the base bits
  assign pcFetch = anyCause ? (VectorBase + vecOffset) : pcNext;

endmodule

`default_nettype wire

//--- design/exceptionRecord.sv
`default_nettype none

module exceptionRecord (
  input  logic            clk,
  input  logic            rstN,
  input  logic            savePc,
  input  logic            pcInSelect,
  input  logic            dataAbortCycle2,
  input  logic            recReady,
  input  excPkg::causeT   cause,
  input  excPkg::pcT      pcD,
  input  excPkg::pcT      pcE,
  input  excPkg::pcT      pcM,
  output logic            recValid,
  output logic            recOverflow,
  output excPkg::pcT      recLinkPc,
  output excPkg::excModeT recMode
);

  import excPkg::*;

  // Candidate record for this cycle
  pcT      linkSel;
  excModeT modeSel;

  // Capture request, reset alone is not recorded
  logic capture;
  // Held record will not leave on this edge
  logic pending;

  assign capture = savePc & (|cause[CauseFiq:CauseUndefined]);
  assign pending = recValid & ~recReady;

  // Aborted instruction sits in W, its PC still in pcM
  always_comb begin
    if (dataAbortCycle2) begin
      linkSel = pcM;
    end else if (pcInSelect) begin
      linkSel = pcE;
    end else begin
      // Interrupt resumes at the instruction held in D
      linkSel = pcD;
    end
  end

  // Same ranking as the vector encoder
  always_comb begin
    if (cause[CauseFiq]) begin
      modeSel = ModeFiq;
    end else if (cause[CauseIrq]) begin
      modeSel = ModeIrq;
    end else if (cause[CauseDataAbort] || cause[CausePrefetchAbort]) begin
      modeSel = ModeAbt;
    end else if (cause[CauseUndefined] && !cause[CauseSwi]) begin
      modeSel = ModeUnd;
    end else begin
      modeSel = ModeSvc;
    end
  end

  // Stream control
  always_ff @(posedge clk or negedge rstN) begin
    if (!rstN) begin
      recValid    <= 1'b0;
      recOverflow <= 1'b0;
    end else begin
      if (capture && !pending) begin
        recValid <= 1'b1;
      end else if (recValid && recReady) begin
        recValid <= 1'b0;
      end
      // Sticky until reset
      if (capture && pending) begin
        recOverflow <= 1'b1;
      end
    end
  end

  // Record payload
  always_ff @(posedge clk) begin
    if (capture && !pending) begin
      recLinkPc <= linkSel;
      recMode   <= modeSel;
    end
  end

  // Stalled record keeps its data until taken
  recStable : assert property (@(posedge clk) disable iff (!rstN)
    (recValid && !recReady) |=>
      (recValid && $stable(recLinkPc) && $stable(recMode)));

endmodule

`default_nettype wire

//--- design/exceptionUnit.sv
`default_nettype none

module exceptionUnit #(
  parameter excPkg::pcT VectorBase = '0
) (
  input  logic            clk,
  input  logic            rstN,
  input  logic            undefinedInstrE,
  input  logic            swiE,
  input  logic            prefetchAbortE,
  input  logic            dataAbort,
  input  logic            irq,
  input  logic            fiq,
  input  logic            irqEnabled,
  input  logic            fiqEnabled,
  input  logic            hazardStallD,
  input  excPkg::pcT      pcD,
  input  excPkg::pcT      pcE,
  input  excPkg::pcT      pcM,
  input  excPkg::pcT      pcNext,
  input  logic            recReady,
  output logic            flushD,
  output logic            flushE,
  output logic            flushM,
  output logic            flushW,
  output logic            stallD,
  output logic            resetMicrop,
  output logic            dataAbortCycle2,
  output excPkg::pcT      pcFetch,
  output logic            recValid,
  output excPkg::pcT      recLinkPc,
  output excPkg::excModeT recMode,
  output logic            recOverflow
);

  import excPkg::*;

  // Handler outputs
  flushT flush;
  causeT cause;
  logic  excStallD;
  logic  savePc;
  logic  pcInSelect;

  // Token pipe
  logic  clearF;
  logic  clearD;
  logic  clearM;

  exceptionHandler handler0 (
    .clk             (clk),
    .rstN            (rstN),
    .undefinedInstrE (undefinedInstrE),
    .swiE            (swiE),
    .prefetchAbortE  (prefetchAbortE),
    .dataAbort       (dataAbort),
    .irq             (irq),
    .fiq             (fiq),
    .irqEnabled      (irqEnabled),
    .fiqEnabled      (fiqEnabled),
    .clearD          (clearD),
    .clearM          (clearM),
    .dataAbortCycle2 (dataAbortCycle2),
    .clearF          (clearF),
    .stallD          (excStallD),
    .resetMicrop     (resetMicrop),
    .savePc          (savePc),
    .pcInSelect      (pcInSelect),
    .flush           (flush),
    .cause           (cause)
  );

  clearTokenPipe tokenPipe0 (
    .clk          (clk),
    .rstN         (rstN),
    .clearF       (clearF),
    .hazardStallD (hazardStallD),
    .flush        (flush),
    .clearD       (clearD),
    .clearM       (clearM)
  );

  vectorSelect #(
    .VectorBase (VectorBase)
  ) vecSel0 (
    .cause   (cause),
    .pcNext  (pcNext),
    .pcFetch (pcFetch)
  );

  exceptionRecord record0 (
    .clk             (clk),
    .rstN            (rstN),
    .savePc          (savePc),
    .pcInSelect      (pcInSelect),
    .dataAbortCycle2 (dataAbortCycle2),
    .recReady        (recReady),
    .cause           (cause),
    .pcD             (pcD),
    .pcE             (pcE),
    .pcM             (pcM),
    .recValid        (recValid),
    .recOverflow     (recOverflow),
    .recLinkPc       (recLinkPc),
    .recMode         (recMode)
  );

  assign flushD = flush[FlushD];
  assign flushE = flush[FlushE];
  assign flushM = flush[FlushM];
  assign flushW = flush[FlushW];
  // Hazard unit stall merged with the exception stall
  assign stallD = excStallD | hazardStallD;

endmodule

`default_nettype wire

//--- test/exceptionModel.svh
`ifndef EXCEPTION_MODEL_SVH
`define EXCEPTION_MODEL_SVH

// Modeled registers of the control path
logic    mDaCycle2;
logic    mIrqEn;
logic    mFiqEn;
logic    mTokD;
logic    mTokE;
logic    mTokM;
logic    mRecValid;
logic    mRecOverflow;
pcT      mRecLink;
excModeT mRecMode;

// Expected values for the current cycle
flushT   eFlush;
logic    eStallD;
logic    eClearF;
logic    eCapture;
pcT      eFetch;
pcT      eLink;
excModeT eMode;

task automatic resetModel();
  mDaCycle2    = 1'b0;
  mIrqEn       = 1'b0;
  mFiqEn       = 1'b0;
  mTokD        = 1'b0;
  mTokE        = 1'b0;
  mTokM        = 1'b0;
  mRecValid    = 1'b0;
  mRecOverflow = 1'b0;
endtask

// Expected outputs from model state and the inputs of this cycle
task automatic predictCycle();
  logic eExc;
  logic intReq;
  logic fiqReq;
  logic take;
  eExc    = undefinedInstrE | swiE | prefetchAbortE;
  fiqReq  = fiq & mFiqEn;
  intReq  = fiqReq | (irq & mIrqEn);
  take    = 1'b0;
  eFlush  = '0;
  eStallD = 1'b0;
  eClearF = 1'b0;
  // Layout is D E M W
  if (dataAbort || mDaCycle2) begin
    eFlush  = dataAbort ? 4'b1111 : 4'b1011;
    eStallD = dataAbort;
  end else if (eExc) begin
    eFlush = 4'b1010;
  end else if (intReq && mTokM) begin
    // Older instructions gone, interrupt taken
    eFlush = 4'b1000;
    take   = 1'b1;
  end else if (intReq) begin
    eClearF = 1'b1;
    // Bubbles into E while the token waits in D
    eFlush  = mTokD ? 4'b0100 : 4'b0000;
    eStallD = mTokD;
  end
  eStallD  = eStallD | hazardStallD;
  eCapture = 1'b1;
  // Highest cause picks both the vector and the mode
  if (take && fiqReq) begin
    eFetch = TbVectorBase + VecFiq;
    eMode  = ModeFiq;
  end else if (take) begin
    eFetch = TbVectorBase + VecIrq;
    eMode  = ModeIrq;
  end else if (mDaCycle2) begin
    eFetch = TbVectorBase + VecDataAbort;
    eMode  = ModeAbt;
  end else if (prefetchAbortE) begin
    eFetch = TbVectorBase + VecPrefetchAbort;
    eMode  = ModeAbt;
  end else if (swiE) begin
    eFetch = TbVectorBase + VecSwi;
    eMode  = ModeSvc;
  end else if (undefinedInstrE) begin
    eFetch = TbVectorBase + VecUndefined;
    eMode  = ModeUnd;
  end else begin
    eFetch   = pcNext;
    eMode    = ModeSvc;
    eCapture = 1'b0;
  end
  // Link follows where the excepting instruction stands
  if (mDaCycle2) begin
    eLink = pcM;
  end else if (eExc) begin
    eLink = pcE;
  end else begin
    eLink = pcD;
  end
endtask

// Clock edge of the model
task automatic advanceModel();
  logic pending;
  logic nextD;
  logic nextE;
  logic nextM;
  pending = mRecValid & ~recReady;
  nextD   = eFlush[FlushD] ? 1'b0 : (hazardStallD ? mTokD : eClearF);
  // A single token per drain, killed in E by a data abort
  nextE   = mTokD & ~mTokE & ~mTokM & ~dataAbort;
  nextM   = mTokE & ~eFlush[FlushM];
  mTokD   = nextD;
  mTokE   = nextE;
  mTokM   = nextM;
  if (eCapture && !pending) begin
    mRecValid = 1'b1;
    mRecLink  = eLink;
    mRecMode  = eMode;
  end else if (mRecValid && recReady) begin
    mRecValid = 1'b0;
  end
  // New record dropped while one waits
  if (eCapture && pending) begin
    mRecOverflow = 1'b1;
  end
  mDaCycle2 = dataAbort;
  mIrqEn    = irqEnabled;
  mFiqEn    = fiqEnabled;
endtask

`endif

//--- test/exceptionUnitTb.sv
`default_nettype none

module exceptionUnitTb;

  timeunit 1ns;
  timeprecision 100ps;

  import excPkg::*;

  // High vectors
  localparam pcT TbVectorBase  = 32'hFFFF_0000;
  localparam int RandomCycles  = 3000;
  localparam int RecordTimeout = 20;

  logic    clk = 1'b0;
  logic    rstN;
  logic    undefinedInstrE;
  logic    swiE;
  logic    prefetchAbortE;
  logic    dataAbort;
  logic    irq;
  logic    fiq;
  logic    irqEnabled;
  logic    fiqEnabled;
  logic    hazardStallD;
  pcT      pcD;
  pcT      pcE;
  pcT      pcM;
  pcT      pcNext;
  logic    recReady;
  logic    flushD;
  logic    flushE;
  logic    flushM;
  logic    flushW;
  logic    stallD;
  logic    resetMicrop;
  logic    dataAbortCycle2;
  pcT      pcFetch;
  logic    recValid;
  pcT      recLinkPc;
  excModeT recMode;
  logic    recOverflow;

  // Error counters per kind of check
  int flushErrs   = 0;
  int pcErrs      = 0;
  int recErrs     = 0;
  int bitErrs     = 0;
  int timeoutErrs = 0;
  int transfers   = 0;

  exceptionUnit #(.VectorBase(TbVectorBase)) dut0 (.*);

  `include "exceptionModel.svh"

  always #20 clk = ~clk;

  task automatic checkFlush(input flushT got, input flushT exp, input string what);
    if (got !== exp) begin
      flushErrs++;
      $display("[FAIL] %0t: %s got %b expected %b", $time, what, got, exp);
    end
  endtask

  task automatic checkPc(input pcT got, input pcT exp, input string what);
    if (got !== exp) begin
      pcErrs++;
      $display("[FAIL] %0t: %s got %h expected %h", $time, what, got, exp);
    end
  endtask

  task automatic checkBit(input logic got, input logic exp, input string what);
    if (got !== exp) begin
      bitErrs++;
      $display("[FAIL] %0t: %s got %b expected %b", $time, what, got, exp);
    end
  endtask

  task automatic checkRecord(input pcT gotLink, input excModeT gotMode,
                             input pcT expLink, input excModeT expMode);
    if (gotLink !== expLink || gotMode !== expMode) begin
      recErrs++;
      $display("[FAIL] %0t: record got %h/%b expected %h/%b",
               $time, gotLink, gotMode, expLink, expMode);
    end
  endtask

  // Inputs change shortly after the rising edge
  task automatic nextEdge();
    @(posedge clk);
    #2;
  endtask

  task automatic quietInputs();
    dataAbort       = 1'b0;
    undefinedInstrE = 1'b0;
    swiE            = 1'b0;
    prefetchAbortE  = 1'b0;
    irq             = 1'b0;
    fiq             = 1'b0;
    hazardStallD    = 1'b0;
    recReady        = 1'b1;
    pcD             = $urandom() & 32'hFFFF_FFFC;
    pcE             = $urandom() & 32'hFFFF_FFFC;
    pcM             = $urandom() & 32'hFFFF_FFFC;
    pcNext          = $urandom() & 32'hFFFF_FFFC;
  endtask

  task automatic randomInputs();
    // Abort in M never repeats on the next cycle
    dataAbort       = !dataAbort && ($urandom_range(19) == 0);
    undefinedInstrE = ($urandom_range(19) == 0);
    swiE            = ($urandom_range(19) == 0);
    prefetchAbortE  = ($urandom_range(19) == 0);
    // Slow levels so some drains complete
    if ($urandom_range(7) == 0) irq = ~irq;
    if ($urandom_range(7) == 0) fiq = ~fiq;
    if ($urandom_range(7) == 0) irqEnabled = ~irqEnabled;
    if ($urandom_range(7) == 0) fiqEnabled = ~fiqEnabled;
    hazardStallD    = ($urandom_range(7) == 0);
    recReady        = $urandom_range(1);
    pcD             = $urandom() & 32'hFFFF_FFFC;
    pcE             = $urandom() & 32'hFFFF_FFFC;
    pcM             = $urandom() & 32'hFFFF_FFFC;
    pcNext          = $urandom() & 32'hFFFF_FFFC;
  endtask

  // Sample at the falling edge, then step the model
  task automatic checkCycle();
    @(negedge clk);
    predictCycle();
    checkFlush({flushD, flushE, flushM, flushW}, eFlush, "flush");
    checkBit(stallD, eStallD, "stallD");
    checkBit(dataAbortCycle2, mDaCycle2, "dataAbortCycle2");
    checkBit(resetMicrop, dataAbort, "resetMicrop");
    checkPc(pcFetch, eFetch, "pcFetch");
    checkBit(recValid, mRecValid, "recValid");
    checkBit(recOverflow, mRecOverflow, "recOverflow");
    if (mRecValid) checkRecord(recLinkPc, recMode, mRecLink, mRecMode);
    if (recValid && recReady) transfers++;
    advanceModel();
  endtask

  // Directed drain of one interrupt with no competing exception
  task automatic takeInterrupt(input logic useFiq, input excModeT expMode);
    int waited;
    nextEdge();
    quietInputs();
    checkCycle();
    waited = 0;
    while (recValid && waited < RecordTimeout) begin
      nextEdge();
      checkCycle();
      waited++;
    end
    if (recValid) begin
      timeoutErrs++;
      $display("Timeout: record stream did not empty within %0d cycles", RecordTimeout);
    end
    nextEdge();
    irqEnabled = 1'b1;
    fiqEnabled = 1'b1;
    irq        = !useFiq;
    fiq        = useFiq;
    checkCycle();
    waited = 0;
    while (!recValid && waited < RecordTimeout) begin
      nextEdge();
      checkCycle();
      waited++;
    end
    // pcD held since the request, so it is the resume point
    if (recValid) begin
      checkRecord(recLinkPc, recMode, pcD, expMode);
    end else begin
      timeoutErrs++;
      $display("Timeout: no interrupt record within %0d cycles", RecordTimeout);
    end
    nextEdge();
    quietInputs();
    checkCycle();
  endtask

  initial begin
    void'($urandom(32'h43e9d64f));
    rstN       = 1'b0;
    irqEnabled = 1'b0;
    fiqEnabled = 1'b0;
    quietInputs();
    resetModel();
    repeat (4) @(posedge clk);
    @(negedge clk);
    // Reset cause alone selects the base vector
    checkPc(pcFetch, TbVectorBase + VecReset, "pcFetch in reset");
    checkBit(recValid, 1'b0, "recValid in reset");
    nextEdge();
    rstN = 1'b1;
    checkCycle();
    repeat (RandomCycles) begin
      nextEdge();
      randomInputs();
      checkCycle();
    end
    takeInterrupt(1'b0, ModeIrq);
    takeInterrupt(1'b1, ModeFiq);
    // Masked requests never reach the stream
    nextEdge();
    irqEnabled = 1'b0;
    fiqEnabled = 1'b0;
    irq        = 1'b1;
    fiq        = 1'b1;
    checkCycle();
    repeat (RecordTimeout) begin
      nextEdge();
      checkCycle();
      checkBit(recValid, 1'b0, "recValid with interrupts masked");
    end
    $display("Errors: flush %0d, pc %0d, record %0d, control %0d, timeout %0d; records %0d",
             flushErrs, pcErrs, recErrs, bitErrs, timeoutErrs, transfers);
    if (flushErrs + pcErrs + recErrs + bitErrs + timeoutErrs == 0) begin
      $display("Done: no errors");
    end else begin
      $display("Done: errors found");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- all.f
+incdir+test
design/excPkg.sv
design/exceptionHandler.sv
design/clearTokenPipe.sv
design/vectorSelect.sv
design/exceptionRecord.sv
design/exceptionUnit.sv
test/exceptionUnitTb.sv
